// ==== list.f ====
+incdir+hw
hw/eth_hdr_pkg.sv
hw/mac_fsm_pkg.sv
hw/crc32.sv
hw/mac_tx_fifo.sv
hw/mac_rx.sv
hw/mac_tx.sv
hw/mac_top.sv
verification/tb_mac.sv

// ==== Makefile ====
TOP = tb_mac

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

obj_dir/V$(TOP): list.f hw/*.sv hw/*.svh verification/*.sv
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP)

# Fails unless the run prints the pass line
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== verification/tb_mac.sv ====
`timescale 1ns/1ns
`include "mac_consts.svh"

module tb_mac;

  localparam int PAY_OFS   = `MAC_PREAMBLE_LEN + 1 + 14; // First payload byte on the wire
  localparam int OVERHEAD  = PAY_OFS + 4;
  localparam int N_FRAMES  = 11;
  localparam int FRAME_CYC = OVERHEAD + 60;              // Longest frame on the wire
  localparam int GAP_CYC   = 13 + 60 + 8;                // Gap, payload writes, handshake
  localparam int WATCH_NS  = 2 * 4 * (N_FRAMES * (FRAME_CYC + GAP_CYC) + 3 + 10);

  logic                    clk = 1'b0;
  logic                    fsm_rst;
  eth_hdr_pkg::mac_addr_t  dev_mac;
  logic [7:0]              phy_rx_d = 8'h00;
  logic                    phy_rx_v = 1'b0;
  logic [7:0]              phy_tx_d;
  logic                    phy_tx_v;
  logic [7:0]              rx_dat;
  logic                    rx_val;
  logic                    rx_sof;
  logic                    rx_eof;
  logic                    rx_err;
  eth_hdr_pkg::mac_hdr_t   rx_hdr;
  logic [15:0]             rx_len;
  logic [7:0]              tx_dat;
  logic                    tx_val;
  logic                    tx_avl;
  eth_hdr_pkg::mac_addr_t  tx_dst;
  eth_hdr_pkg::ethertype_t tx_type;
  logic                    tx_rdy;
  logic                    tx_busy;

  // Expected receive side of the frame in flight
  logic [7:0]              exp_mem [`MAC_TX_FIFO_DEPTH];
  eth_hdr_pkg::mac_hdr_t   exp_hdr = '0;
  logic [15:0]             exp_len = '0;
  logic                    exp_err = 1'b0;
  logic                    expect_rx = 1'b1;
  logic                    seen_avl = 1'b0;
  int                      corrupt_idx = -1;
  int                      tx_pos = 0;
  int                      rx_idx = 0;
  int                      eof_cnt = 0;
  logic [7:0]              sent_q [$];
  logic [31:0]             seed = 32'd26140;
  string                   test_name = "reset";
  int                      err_cnt = 0;
  int                      test_errs = 0;
  int                      tests_run = 0;
  int                      tests_failed = 0;
  int                      len;

  always #2 clk = ~clk;

  mac_top u_mac_top (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .dev_mac  (dev_mac),
    .phy_rx_d (phy_rx_d),
    .phy_rx_v (phy_rx_v),
    .phy_tx_d (phy_tx_d),
    .phy_tx_v (phy_tx_v),
    .rx_dat   (rx_dat),
    .rx_val   (rx_val),
    .rx_sof   (rx_sof),
    .rx_eof   (rx_eof),
    .rx_err   (rx_err),
    .rx_hdr   (rx_hdr),
    .rx_len   (rx_len),
    .tx_dat   (tx_dat),
    .tx_val   (tx_val),
    .tx_avl   (tx_avl),
    .tx_dst   (tx_dst),
    .tx_type  (tx_type),
    .tx_rdy   (tx_rdy),
    .tx_busy  (tx_busy)
  );

  // PHY loopback, tx_pos is the index of the byte now on phy_tx_d
  always @(negedge clk) begin
    phy_rx_v <= phy_tx_v;
    phy_rx_d <= phy_tx_d ^ ((corrupt_idx >= 0 && tx_pos == PAY_OFS + corrupt_idx) ? 8'h01 : 8'h00);
    if (tx_rdy) tx_pos <= 0;
    else if (phy_tx_v) tx_pos <= tx_pos + 1;
  end

  always @(posedge clk) begin
    if (fsm_rst) begin
      rx_idx  <= 0;
      eof_cnt <= 0;
    end else begin
      if (rx_sof) rx_idx <= 1;
      else if (rx_val) rx_idx <= rx_idx + 1;
      if (rx_eof) eof_cnt <= eof_cnt + 1;
    end
  end

  function automatic logic [7:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[23:16];
  endfunction

  task automatic report_mismatch(input string what, input logic [111:0] exp,
                                 input logic [111:0] act);
    $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    err_cnt++;
  endtask

  task automatic report_event(input string what);
    $display("Error in %s: %s", test_name, what);
    err_cnt++;
  endtask

  a_reset_quiet: assert property (@(posedge clk) disable iff (fsm_rst)
    !seen_avl |-> !(phy_tx_v || tx_busy || rx_val || rx_sof || rx_eof))
    else report_mismatch("idle outputs", '0, $sampled({phy_tx_v, tx_busy, rx_val, rx_sof, rx_eof}));
  a_rdy: assert property (@(posedge clk) disable iff (fsm_rst) tx_avl && !tx_busy |=> tx_rdy)
    else report_event("tx_rdy did not follow tx_avl by one cycle");
  a_tx_start: assert property (@(posedge clk) disable iff (fsm_rst) tx_rdy |=> phy_tx_v)
    else report_event("phy_tx_v did not rise the cycle after tx_rdy");
  a_wire_len: assert property (@(posedge clk) disable iff (fsm_rst)
    $fell(phy_tx_v) |-> tx_pos == OVERHEAD + int'(exp_len))
    else report_mismatch("wire bytes", OVERHEAD + int'(exp_len), $sampled(tx_pos));
  a_hdr: assert property (@(posedge clk) disable iff (fsm_rst) rx_sof |-> rx_hdr == exp_hdr)
    else report_mismatch("rx_hdr", exp_hdr, $sampled(rx_hdr));
  a_dat: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_val |-> rx_dat == exp_mem[rx_sof ? 0 : rx_idx])
    else report_mismatch("rx_dat", exp_mem[$sampled(rx_sof) ? 0 : $sampled(rx_idx)],
                         $sampled(rx_dat));
  a_len: assert property (@(posedge clk) disable iff (fsm_rst) rx_eof |-> rx_len == exp_len)
    else report_mismatch("rx_len", exp_len, $sampled(rx_len));
  a_count: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_eof |-> rx_idx == int'(exp_len))
    else report_mismatch("rx_val bytes", exp_len, $sampled(rx_idx));
  a_err: assert property (@(posedge clk) disable iff (fsm_rst) rx_eof |-> rx_err == exp_err)
    else report_mismatch("rx_err", exp_err, $sampled(rx_err));
  a_eof_time: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_eof |-> !$past(phy_rx_v, 5) && $past(phy_rx_v, 6))
    else report_event("rx_eof did not come 5 cycles after phy_rx_v fell");
  a_filter: assert property (@(posedge clk) disable iff (fsm_rst)
    !expect_rx |-> !(rx_sof || rx_val || rx_eof))
    else report_event("a frame for another address reached the client");

  task automatic send_frame(input eth_hdr_pkg::mac_addr_t dst, input int n,
                            input logic to_us, input int flip);
    eth_hdr_pkg::ethertype_t etype;
    int eofs_before;
    int waited;
    etype = {next_rand(), next_rand()};
    sent_q.delete();
    for (int i = 0; i < n; i++) begin
      sent_q.push_back(next_rand());
    end
    for (int i = 0; i < `MAC_TX_FIFO_DEPTH; i++) begin
      exp_mem[i] = (i < n) ? sent_q[i] : 8'h00; // Zero padding past the payload
    end
    if (flip >= 0) exp_mem[flip] = exp_mem[flip] ^ 8'h01;
    exp_hdr     = {dst, dev_mac, etype};
    exp_len     = 16'((n > `MAC_MIN_PAYLOAD) ? n : `MAC_MIN_PAYLOAD);
    exp_err     = (flip >= 0);
    expect_rx   = to_us;
    corrupt_idx = flip;
    eofs_before = eof_cnt;
    foreach (sent_q[i]) begin
      @(negedge clk);
      tx_val = 1'b1;
      tx_dat = sent_q[i];
    end
    @(negedge clk);
    tx_val   = 1'b0;
    tx_avl   = 1'b1;
    tx_dst   = dst;
    tx_type  = etype;
    seen_avl = 1'b1;
    @(negedge clk);
    tx_avl = 1'b0;
    if (!tx_busy) report_event("tx_avl was not accepted");
    waited = 0;
    while (tx_busy && waited < FRAME_CYC + GAP_CYC) begin
      @(negedge clk);
      waited++;
    end
    if (tx_busy) report_event("tx_busy stayed high long after the frame");
    if (to_us && eof_cnt != eofs_before + 1) report_event("the frame ended without one rx_eof");
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = err_cnt;
  endtask

  task automatic finish_test();
    tests_run++;
    if (err_cnt != test_errs) tests_failed++;
    $display("Test %-14s %s", test_name, (err_cnt == test_errs) ? "passed" : "failed");
  endtask

  initial begin
    fsm_rst = 1'b1;
    dev_mac = 48'h02005E102030;
    tx_dat  = 8'h00;
    tx_val  = 1'b0;
    tx_avl  = 1'b0;
    tx_dst  = '0;
    tx_type = '0;
    repeat (3) @(negedge clk);
    fsm_rst = 1'b0;
    start_test("reset");
    repeat (10) @(negedge clk);
    finish_test();
    start_test("header_own");
    send_frame(dev_mac, 20, 1'b1, -1);
    finish_test();
    start_test("header_bcast");
    send_frame(eth_hdr_pkg::mac_bcast, 50, 1'b1, -1);
    finish_test();
    start_test("payload_fcs");
    repeat (6) begin
      len = 1 + int'(next_rand()) % 60;
      send_frame(dev_mac, len, 1'b1, -1);
    end
    finish_test();
    start_test("bad_fcs");
    len = 1 + int'(next_rand()) % 60;
    send_frame(dev_mac, len, 1'b1, int'(next_rand()) % len);
    finish_test();
    start_test("addr_filter");
    send_frame(48'h021122334455, 30, 1'b0, -1);
    send_frame(dev_mac, 12, 1'b1, -1);                      // Still received after a drop
    finish_test();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCH_NS);
    $display("Watchdog expired after %0d ns with tests still running", WATCH_NS);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== hw/mac_top.sv ====
`timescale 1ns/1ns
`include "mac_consts.svh"

module mac_top (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  eth_hdr_pkg::mac_addr_t  dev_mac,
  input  logic [7:0]              phy_rx_d,
  input  logic                    phy_rx_v,
  output logic [7:0]              phy_tx_d,
  output logic                    phy_tx_v,
  output logic [7:0]              rx_dat,
  output logic                    rx_val,
  output logic                    rx_sof,
  output logic                    rx_eof,
  output logic                    rx_err,
  output eth_hdr_pkg::mac_hdr_t   rx_hdr,
  output logic [15:0]             rx_len,
  input  logic [7:0]              tx_dat,
  input  logic                    tx_val,
  input  logic                    tx_avl,
  input  eth_hdr_pkg::mac_addr_t  tx_dst,
  input  eth_hdr_pkg::ethertype_t tx_type,
  output logic                    tx_rdy,
  output logic                    tx_busy
);

  logic       fifo_rd;
  logic [7:0] fifo_q;
  logic       fifo_empty;

  mac_rx u_rx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .dev_mac (dev_mac),
    .phy_d   (phy_rx_d),
    .phy_v   (phy_rx_v),
    .dat     (rx_dat),
    .val     (rx_val),
    .sof     (rx_sof),
    .eof     (rx_eof),
    .err     (rx_err),
    .hdr     (rx_hdr),
    .len     (rx_len)
  );

  // Client writes the payload here before pulsing tx_avl
  mac_tx_fifo #(
    .DEPTH (`MAC_TX_FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr      (tx_val),
    .wd      (tx_dat),
    .rd      (fifo_rd),
    .q       (fifo_q),
    .empty   (fifo_empty),
    .count   ()
  );

  mac_tx u_tx (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .dev_mac    (dev_mac),
    .avl        (tx_avl),
    .dst        (tx_dst),
    .etype      (tx_type),
    .rdy        (tx_rdy),
    .busy       (tx_busy),
    .fifo_rd    (fifo_rd),
    .fifo_q     (fifo_q),
    .fifo_empty (fifo_empty),
    .phy_d      (phy_tx_d),
    .phy_v      (phy_tx_v)
  );

endmodule

// ==== hw/mac_tx.sv ====
`timescale 1ns/1ns
`include "mac_consts.svh"

module mac_tx (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  eth_hdr_pkg::mac_addr_t  dev_mac,
  input  logic                    avl,
  input  eth_hdr_pkg::mac_addr_t  dst,
  input  eth_hdr_pkg::ethertype_t etype,
  output logic                    rdy,
  output logic                    busy,
  output logic                    fifo_rd,
  input  logic [7:0]              fifo_q,
  input  logic                    fifo_empty,
  output logic [7:0]              phy_d,
  output logic                    phy_v
);

  mac_fsm_pkg::tx_state_t state;
  eth_hdr_pkg::mac_hdr_t  hdr_q;
  logic [3:0]  cnt;
  logic [6:0]  pay_cnt;       // Payload bytes out so far, padding included
  logic [7:0]  nxt_d;
  logic [31:0] crc;
  logic [31:0] fcs;
  logic        crc_v;
  logic        pad_done;

  assign fcs      = ~crc;
  assign pad_done = (pay_cnt >= 7'(`MAC_MIN_PAYLOAD - 1));
  assign crc_v    = state inside {mac_fsm_pkg::tx_dst_s, mac_fsm_pkg::tx_src_s,
                                  mac_fsm_pkg::tx_type_s, mac_fsm_pkg::tx_pay_s,
                                  mac_fsm_pkg::tx_pad_s};
  // Pop one cycle ahead so fifo_q is ready when the byte is loaded
  assign fifo_rd  = !fifo_empty &&
                    ((state == mac_fsm_pkg::tx_type_s && cnt == 4'd1) ||
                     state == mac_fsm_pkg::tx_pay_s);

  crc32 u_crc (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (state == mac_fsm_pkg::tx_pre_s),
    .d       (nxt_d),
    .v       (crc_v),
    .crc     (crc),
    .ok      ()
  );

  // Byte loaded into phy_d at the next edge
  always_comb begin
    nxt_d = 8'h00;
    case (state)
      mac_fsm_pkg::tx_pre_s: nxt_d = (cnt == 4'(`MAC_PREAMBLE_LEN)) ? `MAC_SFD : 8'h55;
      mac_fsm_pkg::tx_dst_s: nxt_d = hdr_q.dst[3'd5 - cnt[2:0]];
      mac_fsm_pkg::tx_src_s: nxt_d = hdr_q.src[3'd5 - cnt[2:0]];
      mac_fsm_pkg::tx_type_s: nxt_d = hdr_q.etype[~cnt[0]];
      mac_fsm_pkg::tx_pay_s: nxt_d = fifo_q;
      mac_fsm_pkg::tx_fcs_s: nxt_d = fcs[{cnt[1:0], 3'b000} +: 8]; // LSB first
      default: nxt_d = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= mac_fsm_pkg::tx_idle_s;
      cnt     <= '0;
      pay_cnt <= '0;
      rdy     <= 1'b0;
      busy    <= 1'b0;
      phy_v   <= 1'b0;
    end else begin
      rdy   <= 1'b0;
      phy_v <= (state != mac_fsm_pkg::tx_idle_s) && (state != mac_fsm_pkg::tx_gap_s);
      cnt   <= cnt + 1'b1;
      case (state)
        mac_fsm_pkg::tx_idle_s: begin
          cnt     <= '0;
          pay_cnt <= '0;
          if (avl) begin
            state <= mac_fsm_pkg::tx_pre_s;
            rdy   <= 1'b1;
            busy  <= 1'b1;
          end
        end
        mac_fsm_pkg::tx_pre_s: if (cnt == 4'(`MAC_PREAMBLE_LEN)) begin
          state <= mac_fsm_pkg::tx_dst_s;
          cnt   <= '0;
        end
        mac_fsm_pkg::tx_dst_s: if (cnt == 4'd5) begin
          state <= mac_fsm_pkg::tx_src_s;
          cnt   <= '0;
        end
        mac_fsm_pkg::tx_src_s: if (cnt == 4'd5) begin
          state <= mac_fsm_pkg::tx_type_s;
          cnt   <= '0;
        end
        mac_fsm_pkg::tx_type_s: if (cnt == 4'd1) begin
          state <= fifo_rd ? mac_fsm_pkg::tx_pay_s : mac_fsm_pkg::tx_pad_s;
          cnt   <= '0;
        end
        mac_fsm_pkg::tx_pay_s: begin
          cnt     <= '0;
          pay_cnt <= pay_cnt + 1'b1;
          if (!fifo_rd) state <= pad_done ? mac_fsm_pkg::tx_fcs_s : mac_fsm_pkg::tx_pad_s;
        end
        mac_fsm_pkg::tx_pad_s: begin
          cnt     <= '0;
          pay_cnt <= pay_cnt + 1'b1;
          if (pad_done) state <= mac_fsm_pkg::tx_fcs_s;
        end
        mac_fsm_pkg::tx_fcs_s: if (cnt == 4'd3) begin
          state <= mac_fsm_pkg::tx_gap_s;
          cnt   <= '0;
        end
        mac_fsm_pkg::tx_gap_s: if (cnt == 4'd12) begin // Interframe gap
          state <= mac_fsm_pkg::tx_idle_s;
          busy  <= 1'b0;
        end
        default: state <= mac_fsm_pkg::tx_idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    phy_d <= nxt_d;
    if (state == mac_fsm_pkg::tx_idle_s && avl) begin
      hdr_q.dst   <= dst;
      hdr_q.src   <= dev_mac;
      hdr_q.etype <= etype;
    end
  end

  a_no_gap: assert property (@(posedge clk) disable iff (fsm_rst)
    phy_v && state != mac_fsm_pkg::tx_gap_s |=> phy_v);
  a_busy_frame: assert property (@(posedge clk) disable iff (fsm_rst) phy_v |-> busy);

endmodule

// ==== hw/mac_rx.sv ====
`timescale 1ns/1ns
`include "mac_consts.svh"

module mac_rx (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  eth_hdr_pkg::mac_addr_t dev_mac,
  input  logic [7:0]             phy_d,
  input  logic                   phy_v,
  output logic [7:0]             dat,
  output logic                   val,
  output logic                   sof,
  output logic                   eof,
  output logic                   err,
  output eth_hdr_pkg::mac_hdr_t  hdr,
  output logic [15:0]            len
);

  mac_fsm_pkg::rx_state_t state;
  logic [3:0]      cnt;      // Header byte index
  logic [15:0]     pcnt;     // Bytes after the header, FCS included
  logic [111:0]    hdr_sr;
  logic [3:0][7:0] dl;       // Holds the last four bytes back so the FCS never leaves
  logic [3:0]      eof_dly;
  logic            sfd;
  logic            crc_v;
  logic            crc_ok;
  logic            dst_hit;
  logic            frame_end;

  assign sfd       = phy_v && (phy_d == `MAC_SFD) && (state == mac_fsm_pkg::rx_pre_s);
  assign crc_v     = phy_v && (state == mac_fsm_pkg::rx_hdr_s || state == mac_fsm_pkg::rx_pay_s);
  assign frame_end = !phy_v && (state == mac_fsm_pkg::rx_pay_s);
  // Destination sits in the low six bytes once cnt reaches 6
  assign dst_hit   = (hdr_sr[47:0] == dev_mac) || (hdr_sr[47:0] == eth_hdr_pkg::mac_bcast);

  crc32 u_crc (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (sfd),
    .d       (phy_d),
    .v       (crc_v),
    .crc     (),
    .ok      (crc_ok)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= mac_fsm_pkg::rx_idle_s;
      cnt     <= '0;
      pcnt    <= '0;
      val     <= 1'b0;
      sof     <= 1'b0;
      eof     <= 1'b0;
      eof_dly <= '0;
    end else begin
      val     <= 1'b0;
      sof     <= 1'b0;
      eof_dly <= {eof_dly[2:0], frame_end};
      eof     <= eof_dly[3];
      case (state)
        mac_fsm_pkg::rx_idle_s: if (phy_v) state <= mac_fsm_pkg::rx_pre_s;
        mac_fsm_pkg::rx_pre_s: begin
          cnt <= '0;
          if (!phy_v) state <= mac_fsm_pkg::rx_idle_s;
          else if (sfd) state <= mac_fsm_pkg::rx_hdr_s;
        end
        mac_fsm_pkg::rx_hdr_s: begin
          cnt  <= cnt + 1'b1;
          pcnt <= '0;
          if (!phy_v) state <= mac_fsm_pkg::rx_idle_s; // Runt
          else if (cnt == 4'd6 && !dst_hit) state <= mac_fsm_pkg::rx_drop_s;
          else if (cnt == 4'd13) state <= mac_fsm_pkg::rx_pay_s;
        end
        mac_fsm_pkg::rx_pay_s: begin
          if (phy_v) begin
            pcnt <= pcnt + 1'b1;
            val  <= (pcnt >= 16'd4);
            sof  <= (pcnt == 16'd4);
          end else begin
            state <= mac_fsm_pkg::rx_idle_s;
          end
        end
        mac_fsm_pkg::rx_drop_s: if (!phy_v) state <= mac_fsm_pkg::rx_idle_s;
        default: state <= mac_fsm_pkg::rx_idle_s;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phy_v) dl <= {dl[2:0], phy_d};
    if (phy_v && state == mac_fsm_pkg::rx_hdr_s) hdr_sr <= {hdr_sr[103:0], phy_d};
    if (sfd) len <= '0;
    if (phy_v && state == mac_fsm_pkg::rx_pay_s && pcnt >= 16'd4) begin
      dat <= dl[3];
      len <= len + 1'b1;
      if (pcnt == 16'd4) hdr <= hdr_sr;
    end
    // 64 bytes after the SFD is 14 header + 46 payload + 4 FCS
    if (frame_end) err <= !crc_ok || (pcnt < 16'(`MAC_MIN_PAYLOAD + 4));
  end

  a_sof_eof: assert property (@(posedge clk) disable iff (fsm_rst) !(sof && eof));
  a_val_idle: assert property (@(posedge clk) disable iff (fsm_rst)
    state == mac_fsm_pkg::rx_idle_s |-> !val);

endmodule

// ==== hw/mac_tx_fifo.sv ====
`timescale 1ns/1ns

module mac_tx_fifo #(
  parameter int DEPTH = 64
) (
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       wr,
  input  logic [7:0] wd,
  input  logic       rd,
  output logic [7:0] q,
  output logic       empty,
  output logic [6:0] count
);

  localparam int AW = $clog2(DEPTH);

  logic [7:0]  mem [DEPTH];
  logic [AW:0] wp;            // Extra bit tells full from empty
  logic [AW:0] rp;
  logic [AW:0] diff;
  logic        full;

  assign diff  = wp - rp;
  assign count = 7'(diff);
  assign empty = (wp == rp);
  assign full  = (diff == (AW+1)'(DEPTH));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wp <= '0;
      rp <= '0;
    end else begin
      if (wr && !full) wp <= wp + 1'b1;
      if (rd && !empty) rp <= rp + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr && !full) mem[wp[AW-1:0]] <= wd;
    if (rd && !empty) q <= mem[rp[AW-1:0]]; // Data one cycle after the pop
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (fsm_rst) wr |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (fsm_rst) rd |-> !empty);

endmodule

// ==== hw/crc32.sv ====
`timescale 1ns/1ns
`include "mac_consts.svh"

module crc32 (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        clr,
  input  logic [7:0]  d,
  input  logic        v,
  output logic [31:0] crc,
  output logic        ok
);

  // One byte through the reflected polynomial, LSB first
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
    logic [31:0] r;
    r = c ^ {24'h0, b};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst || clr) begin
      crc <= '1;
    end else if (v) begin
      crc <= crc_byte(crc, d);
    end
  end

  assign ok = (crc == `MAC_FCS_RESIDUE);

endmodule

// ==== hw/mac_fsm_pkg.sv ====
package mac_fsm_pkg;

  typedef enum logic [2:0] {
    rx_idle_s,
    rx_pre_s,
    rx_hdr_s,
    rx_pay_s,
    rx_drop_s
  } rx_state_t;

  typedef enum logic [3:0] {
    tx_idle_s,
    tx_pre_s,
    tx_dst_s,
    tx_src_s,
    tx_type_s,
    tx_pay_s,
    tx_pad_s,
    tx_fcs_s,
    tx_gap_s
  } tx_state_t;

endpackage

// ==== hw/eth_hdr_pkg.sv ====
package eth_hdr_pkg;

  // Byte 5 goes out first
  typedef logic [5:0][7:0] mac_addr_t;

  typedef logic [1:0][7:0] ethertype_t; // High byte first

  // Wire order, first byte at the top
  typedef struct packed {
    mac_addr_t  dst;
    mac_addr_t  src;
    ethertype_t etype;
  } mac_hdr_t;

  localparam mac_addr_t mac_bcast = '1;

endpackage

// ==== hw/mac_consts.svh ====
`ifndef MAC_CONSTS_SVH
`define MAC_CONSTS_SVH

// Frame layout on the wire
`define MAC_PREAMBLE_LEN  7
`define MAC_SFD           8'hD5

// Shorter payloads are zero padded up to this
`define MAC_MIN_PAYLOAD   46

// Reflected CRC-32 register left behind once a good FCS has been shifted in
`define MAC_FCS_RESIDUE   32'hDEBB20E3

// One transmit payload, in bytes
`define MAC_TX_FIFO_DEPTH 64

`endif
